/* rtl/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// address map, each top is exclusive
`define BRAM_BASE_ADDR 32'h0000_0000
`define BRAM_TOP_ADDR 32'h0000_1000

`define CLINT_BASE_ADDR 32'h0200_0000
`define CLINT_TOP_ADDR 32'h0201_0000

`define UART_BASE_ADDR 32'h1000_0000
`define UART_TOP_ADDR 32'h1000_0010

// words of 32 bits, enough to fill the ram region
`define BRAM_DEPTH 1024

// kept short so a frame costs only 80 clocks in simulation
`define UART_CLKS_PER_BIT 8

`endif

/* rtl/soc_pkg.sv */
package soc_pkg;

  // request as the cpu would issue it
  typedef struct packed {
    logic valid;
    logic instr; // instruction fetch
    logic [31 : 0] addr;
    logic [31 : 0] wdata;
    logic [3 : 0] wstrb; // all zero for a read
  } mem_req_t;

  // answer from a target, error is only ever set by the decoder
  typedef struct packed {
    logic ready;
    logic error;
    logic [31 : 0] rdata;
  } mem_rsp_t;

endpackage

/* rtl/bus_decoder.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module bus_decoder
(
  input  logic clock,
  input  logic reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output soc_pkg::mem_req_t bram_req,
  output soc_pkg::mem_req_t clint_req,
  output soc_pkg::mem_req_t uart_req,
  input  soc_pkg::mem_rsp_t bram_rsp,
  input  soc_pkg::mem_rsp_t clint_rsp,
  input  soc_pkg::mem_rsp_t uart_rsp
);

  logic bram_sel;
  logic clint_sel;
  logic uart_sel;
  logic err_now;
  logic err_q;
  logic [31 : 0] base;
  logic [31 : 0] offset;

  assign bram_sel = (req.addr >= `BRAM_BASE_ADDR) && (req.addr < `BRAM_TOP_ADDR);
  assign clint_sel = (req.addr >= `CLINT_BASE_ADDR) && (req.addr < `CLINT_TOP_ADDR);
  assign uart_sel = (req.addr >= `UART_BASE_ADDR) && (req.addr < `UART_TOP_ADDR);
  assign err_now = req.valid & ~(bram_sel | clint_sel | uart_sel);

  always_comb begin
    base = 32'h0;
    if (bram_sel) begin
      base = `BRAM_BASE_ADDR;
    end else if (clint_sel) begin
      base = `CLINT_BASE_ADDR;
    end else if (uart_sel) begin
      base = `UART_BASE_ADDR;
    end
  end

  assign offset = req.addr - base;

  // every target sees the same fields, only the selected one sees valid
  always_comb begin
    bram_req = req;
    bram_req.valid = req.valid & bram_sel;
    bram_req.addr = offset;
    clint_req = req;
    clint_req.valid = req.valid & clint_sel;
    clint_req.addr = offset;
    uart_req = req;
    uart_req.valid = req.valid & uart_sel;
    uart_req.addr = offset;
  end

  // the error answer goes out one cycle after valid and only once per request
  always_ff @(posedge clock) begin
    if (reset == 1) begin
      err_q <= 0;
    end else begin
      err_q <= err_now & ~err_q;
    end
  end

  always_comb begin
    rsp = '0;
    if (bram_rsp.ready) begin
      rsp = bram_rsp;
    end else if (clint_rsp.ready) begin
      rsp = clint_rsp;
    end else if (uart_rsp.ready) begin
      rsp = uart_rsp;
    end else if (err_q) begin
      rsp.ready = 1;
      rsp.error = 1;
    end
  end

  a_one_target : assert property (@(posedge clock) disable iff (reset)
    $onehot0({bram_req.valid, clint_req.valid, uart_req.valid}));

  // targets answer one request at a time, so two answers never meet in the mux
  a_one_answer : assert property (@(posedge clock) disable iff (reset)
    $onehot0({bram_rsp.ready, clint_rsp.ready, uart_rsp.ready, err_q}));

endmodule

/* rtl/bram.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module bram
(
  input  logic clock,
  input  logic reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp
);

  localparam int ADDR_W = $clog2(`BRAM_DEPTH);

  logic [31 : 0] mem [0 : `BRAM_DEPTH - 1];
  logic [ADDR_W - 1 : 0] index;
  logic access;
  logic ready_q;
  logic [31 : 0] rdata_q;

  assign index = req.addr[ADDR_W + 1 : 2]; // byte offset down to a word index
  assign access = req.valid & ~ready_q; // valid is still high in the ready cycle

  always_ff @(posedge clock) begin
    if (reset == 1) begin
      ready_q <= 0;
    end else begin
      ready_q <= access;
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[index][8 * i +: 8] <= req.wdata[8 * i +: 8];
        end
      end
      rdata_q <= mem[index]; // old word on a write, nobody looks at it then
    end
  end

  assign rsp = '{ready: ready_q, error: 1'b0, rdata: rdata_q};

  a_ready_pulse : assert property (@(posedge clock) disable iff (reset)
    rsp.ready |-> req.valid ##1 !rsp.ready);

endmodule

/* rtl/clint.sv */
`timescale 1ns/100ps

module clint
(
  input  logic clock,
  input  logic reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic msip,
  output logic mtip
);

  logic access;
  logic write;
  logic [15 : 0] offset;
  logic ready_q;
  logic msip_q;
  logic mtip_q;
  logic [63 : 0] mtime;
  logic [63 : 0] mtimecmp;
  logic [31 : 0] rdata_q;

  function automatic logic [31 : 0] merge_bytes(input logic [31 : 0] old_word,
                                                input logic [31 : 0] new_word,
                                                input logic [3 : 0] strb);
    logic [31 : 0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8 * i +: 8] = new_word[8 * i +: 8];
      end
    end
    return result;
  endfunction

  assign access = req.valid & ~ready_q;
  assign write = access & (|req.wstrb);
  assign offset = req.addr[15 : 0]; // the region is 64 KiB wide

  always_ff @(posedge clock) begin
    if (reset == 1) begin
      ready_q <= 0;
      msip_q <= 0;
      mtip_q <= 0;
      mtime <= '0;
      mtimecmp <= '1;
    end else begin
      ready_q <= access;
      mtip_q <= (mtime >= mtimecmp); // sees both registers a cycle late
      mtime <= mtime + 64'd1;
      if (write) begin
        case (offset)
          16'h0000: if (req.wstrb[0]) begin
            msip_q <= req.wdata[0];
          end
          16'h4000: mtimecmp[31 : 0] <= merge_bytes(mtimecmp[31 : 0], req.wdata, req.wstrb);
          16'h4004: mtimecmp[63 : 32] <= merge_bytes(mtimecmp[63 : 32], req.wdata, req.wstrb);
          16'hBFF8: mtime <= {mtime[63 : 32], merge_bytes(mtime[31 : 0], req.wdata, req.wstrb)};
          16'hBFFC: mtime <= {merge_bytes(mtime[63 : 32], req.wdata, req.wstrb), mtime[31 : 0]};
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      case (offset)
        16'h0000: rdata_q <= {31'b0, msip_q};
        16'h4000: rdata_q <= mtimecmp[31 : 0];
        16'h4004: rdata_q <= mtimecmp[63 : 32];
        16'hBFF8: rdata_q <= mtime[31 : 0];
        16'hBFFC: rdata_q <= mtime[63 : 32];
        default: rdata_q <= 32'h0;
      endcase
    end
  end

  assign rsp = '{ready: ready_q, error: 1'b0, rdata: rdata_q};
  assign msip = msip_q;
  assign mtip = mtip_q;

  // ready answers a request that the master still holds unchanged
  a_ready_rule : assert property (@(posedge clock) disable iff (reset)
    rsp.ready |-> req.valid && $stable(req.addr));

endmodule

/* rtl/uart.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module uart
(
  input  logic clock,
  input  logic reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic tx
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);

  logic data_wr;
  logic go;
  logic ready_q;
  logic busy;
  logic [9 : 0] frame_q;
  logic [CNT_W - 1 : 0] bit_cnt;
  logic [3 : 0] bit_idx;
  logic [31 : 0] rdata_q;

  assign data_wr = req.valid & (req.addr[3 : 2] == 2'd0) & (|req.wstrb);

  // a data write waits here while a frame is still going out
  assign go = req.valid & ~ready_q & (~data_wr | ~busy);

  always_ff @(posedge clock) begin
    if (reset == 1) begin
      ready_q <= 0;
      busy <= 0;
      frame_q <= '1; // line idles high
      bit_cnt <= '0;
      bit_idx <= '0;
    end else begin
      ready_q <= go;
      if (go && data_wr) begin
        busy <= 1;
        frame_q <= {1'b1, req.wdata[7 : 0], 1'b0}; // stop, data lsb first, start
        bit_cnt <= '0;
        bit_idx <= '0;
      end else if (busy) begin
        if (bit_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1)) begin
          bit_cnt <= '0;
          frame_q <= {1'b1, frame_q[9 : 1]};
          if (bit_idx == 4'd9) begin
            busy <= 0; // stop bit has had its full time
          end else begin
            bit_idx <= bit_idx + 4'd1;
          end
        end else begin
          bit_cnt <= bit_cnt + CNT_W'(1);
        end
      end
    end
  end

  // offset 0x4 is the status word, everything else reads zero
  always_ff @(posedge clock) begin
    if (go) begin
      if (req.addr[3 : 2] == 2'd1) begin
        rdata_q <= {31'b0, busy};
      end else begin
        rdata_q <= 32'h0;
      end
    end
  end

  assign tx = frame_q[0];
  assign rsp = '{ready: ready_q, error: 1'b0, rdata: rdata_q};

  a_idle_high : assert property (@(posedge clock) disable iff (reset)
    !busy |-> tx);

endmodule

/* rtl/soc_bus.sv */
`timescale 1ns/100ps

module soc_bus
(
  input  logic clock,
  input  logic reset,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic tx,
  output logic msip,
  output logic mtip
);

  import soc_pkg::*;

  mem_req_t bram_req;
  mem_req_t clint_req;
  mem_req_t uart_req;
  mem_rsp_t bram_rsp;
  mem_rsp_t clint_rsp;
  mem_rsp_t uart_rsp;

  bus_decoder bus_decoder_comp
  (
    .clock (clock),
    .reset (reset),
    .req (req),
    .rsp (rsp),
    .bram_req (bram_req),
    .clint_req (clint_req),
    .uart_req (uart_req),
    .bram_rsp (bram_rsp),
    .clint_rsp (clint_rsp),
    .uart_rsp (uart_rsp)
  );

  bram bram_comp
  (
    .clock (clock),
    .reset (reset),
    .req (bram_req),
    .rsp (bram_rsp)
  );

  clint clint_comp
  (
    .clock (clock),
    .reset (reset),
    .req (clint_req),
    .rsp (clint_rsp),
    .msip (msip),
    .mtip (mtip)
  );

  uart uart_comp
  (
    .clock (clock),
    .reset (reset),
    .req (uart_req),
    .rsp (uart_rsp),
    .tx (tx)
  );

endmodule

/* sim/soc_bus_tb.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module soc_bus_tb;

  import soc_pkg::*;

  localparam int CLK_NS = 8;
  localparam int NUM_ENTRIES = 27;
  localparam int FRAME_CLKS = 10 * `UART_CLKS_PER_BIT;
  localparam int WATCHDOG_CYCLES = (NUM_ENTRIES + 8) * 64 + 2 * FRAME_CLKS;
  localparam logic [31 : 0] MTIME_LO = `CLINT_BASE_ADDR + 32'hBFF8;

  typedef struct packed {
    logic [31 : 0] addr;
    logic [31 : 0] wdata;
    logic [3 : 0] wstrb;
    logic [31 : 0] exp_rdata;
    logic exp_error;
    logic check_data; // a ram write returns the old word
  } entry_t;

  logic clock;
  logic reset;
  mem_req_t req;
  mem_rsp_t rsp;
  logic tx;
  logic msip;
  logic mtip;
  entry_t table_q [NUM_ENTRIES];
  int fill_idx;
  int errors;
  int tests;
  logic [7 : 0] rx_bytes [$];

  soc_bus uut (
    .clock (clock),
    .reset (reset),
    .req (req),
    .rsp (rsp),
    .tx (tx),
    .msip (msip),
    .mtip (mtip)
  );

  initial begin
    clock = 0;
    forever #(CLK_NS / 2) clock = ~clock;
  end

  task automatic report_error(input string msg);
    errors++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: failed", tests, name);
    end
  endtask

  // request goes out just after an edge and stays up through the ready cycle
  task automatic bus_access(input logic [31 : 0] addr, input logic [31 : 0] wdata,
                            input logic [3 : 0] wstrb, output mem_rsp_t got, output int cycles);
    req = '{valid: 1'b1, instr: 1'b0, addr: addr, wdata: wdata, wstrb: wstrb};
    cycles = 0;
    got = '0;
    while (!got.ready) begin
      @(posedge clock);
      #1;
      cycles++;
      got = rsp;
    end
    @(posedge clock);
    #1;
    req = '0;
  endtask

  task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp, input logic check_data,
                           input int cycles, input int exp_cycles);
    if (got.error !== exp.error) begin
      report_error($sformatf("error flag %b, expected %b", got.error, exp.error));
    end
    if (check_data && got.rdata !== exp.rdata) begin
      report_error($sformatf("rdata %h, expected %h", got.rdata, exp.rdata));
    end
    if (exp_cycles > 0 && cycles != exp_cycles) begin
      report_error($sformatf("ready after %0d cycles, expected %0d", cycles, exp_cycles));
    end
  endtask

  task automatic check_irq(input logic exp_msip, input logic exp_mtip);
    if (msip !== exp_msip || mtip !== exp_mtip) begin
      report_error($sformatf("msip %b mtip %b, expected %b %b", msip, mtip, exp_msip, exp_mtip));
    end
  endtask

  task automatic check_byte(input int idx, input logic [7 : 0] got, input logic [7 : 0] exp);
    if (got !== exp) begin
      report_error($sformatf("uart byte %0d is %h, expected %h", idx, got, exp));
    end
  endtask

  task automatic add_entry(input logic [31 : 0] addr, input logic [31 : 0] wdata,
                           input logic [3 : 0] wstrb, input logic [31 : 0] exp_rdata,
                           input logic exp_error, input logic check_data);
    table_q[fill_idx] = {addr, wdata, wstrb, exp_rdata, exp_error, check_data};
    fill_idx++;
  endtask

  task automatic fill_table();
    logic [31 : 0] rnd [4];
    fill_idx = 0;
    for (int i = 0; i < 4; i++) begin
      rnd[i] = $urandom();
      add_entry(32'h10 + 4 * i, rnd[i], 4'hF, 32'h0, 0, 0);
    end
    for (int i = 0; i < 4; i++) begin
      add_entry(32'h10 + 4 * i, 32'h0, 4'h0, rnd[i], 0, 1);
    end
    // only bytes 0 and 2 take the new value
    add_entry(32'h40, 32'h1122_3344, 4'hF, 32'h0, 0, 0);
    add_entry(32'h40, 32'hAABB_CCDD, 4'b0101, 32'h0, 0, 0);
    add_entry(32'h40, 32'h0, 4'h0, 32'h11BB_33DD, 0, 1);
    add_entry(`BRAM_BASE_ADDR, 32'hCAFE_0001, 4'hF, 32'h0, 0, 0);
    add_entry(`BRAM_TOP_ADDR - 4, 32'hCAFE_0FFC, 4'hF, 32'h0, 0, 0);
    add_entry(`BRAM_BASE_ADDR, 32'h0, 4'h0, 32'hCAFE_0001, 0, 1);
    add_entry(`BRAM_TOP_ADDR - 4, 32'h0, 4'h0, 32'hCAFE_0FFC, 0, 1);
    add_entry(`BRAM_TOP_ADDR, 32'h0, 4'h0, 32'h0, 1, 1);
    add_entry(`BRAM_TOP_ADDR, 32'hDEAD_BEEF, 4'hF, 32'h0, 1, 1);
    add_entry(32'h2000_0000, 32'h0, 4'h0, 32'h0, 1, 1);
    add_entry(`UART_BASE_ADDR - 4, 32'hDEAD_BEEF, 4'hF, 32'h0, 1, 1);
    add_entry(`BRAM_BASE_ADDR, 32'h0, 4'h0, 32'hCAFE_0001, 0, 1); // word 0 must be untouched
    add_entry(`CLINT_BASE_ADDR, 32'h1, 4'hF, 32'h0, 0, 0);
    add_entry(`CLINT_BASE_ADDR, 32'h0, 4'h0, 32'h1, 0, 1);
    // restart mtime near zero with mtimecmp at 100
    add_entry(`CLINT_BASE_ADDR + 32'h4004, 32'h0, 4'hF, 32'h0, 0, 0);
    add_entry(MTIME_LO, 32'h0, 4'hF, 32'h0, 0, 0);
    add_entry(MTIME_LO + 4, 32'h0, 4'hF, 32'h0, 0, 0);
    add_entry(`CLINT_BASE_ADDR + 32'h4000, 32'd100, 4'hF, 32'h0, 0, 0);
    add_entry(`CLINT_BASE_ADDR + 32'h4000, 32'h0, 4'h0, 32'd100, 0, 1);
  endtask

  // decodes tx in the middle of each bit, counted on falling clock edges
  initial begin
    logic [7 : 0] data;
    @(negedge reset);
    forever begin
      @(negedge tx);
      repeat (`UART_CLKS_PER_BIT / 2) @(negedge clock);
      if (tx !== 1'b0) begin
        report_error("start bit not held low");
      end
      for (int i = 0; i < 8; i++) begin
        repeat (`UART_CLKS_PER_BIT) @(negedge clock);
        data[i] = tx;
      end
      repeat (`UART_CLKS_PER_BIT) @(negedge clock);
      if (tx !== 1'b1) begin
        report_error("stop bit not high");
      end
      rx_bytes.push_back(data);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    mem_rsp_t got;
    mem_rsp_t exp;
    int cycles;
    int errs_before;
    int waited;
    logic [31 : 0] first;
    time t_first;
    reset = 1;
    req = '0;
    errors = 0;
    tests = 0;
    void'($urandom(12));
    fill_table();
    repeat (3) @(posedge clock);
    #1;
    reset = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      errs_before = errors;
      bus_access(table_q[i].addr, table_q[i].wdata, table_q[i].wstrb, got, cycles);
      exp = '{ready: 1'b1, error: table_q[i].exp_error, rdata: table_q[i].exp_rdata};
      check_rsp(got, exp, table_q[i].check_data, cycles, 1);
      end_test($sformatf("access at %h", table_q[i].addr), errs_before);
    end

    errs_before = errors;
    check_irq(1, 0);
    waited = 0;
    while (!mtip && waited < 110) begin
      @(posedge clock);
      #1;
      waited++;
    end
    check_irq(1, 1);
    end_test("clint interrupts", errs_before);

    errs_before = errors;
    bus_access(MTIME_LO, 32'h0, 4'h0, got, cycles);
    first = got.rdata;
    bus_access(MTIME_LO, 32'h0, 4'h0, got, cycles);
    if (got.rdata < first) begin
      report_error($sformatf("mtime went back from %0d to %0d", first, got.rdata));
    end
    end_test("mtime reads", errs_before);

    errs_before = errors;
    exp = '{ready: 1'b1, error: 1'b0, rdata: 32'h1};
    bus_access(`UART_BASE_ADDR, 32'h5A, 4'h1, got, cycles);
    t_first = $time;
    check_rsp(got, exp, 0, cycles, 1);
    bus_access(`UART_BASE_ADDR, 32'hC3, 4'h1, got, cycles); // held until the shifter is idle
    check_rsp(got, exp, 0, cycles, 0);
    if ($time - t_first <= FRAME_CLKS * CLK_NS) begin
      report_error("second uart write finished before the first frame ended");
    end
    bus_access(`UART_BASE_ADDR + 4, 32'h0, 4'h0, got, cycles);
    check_rsp(got, exp, 1, cycles, 1);
    waited = 0;
    while (rx_bytes.size() < 2 && waited < 2 * FRAME_CLKS) begin
      @(posedge clock);
      waited++;
    end
    if (rx_bytes.size() != 2) begin
      errors++;
      $display("uart monitor received %0d bytes instead of 2", rx_bytes.size());
    end else begin
      check_byte(0, rx_bytes[0], 8'h5A);
      check_byte(1, rx_bytes[1], 8'hC3);
    end
    end_test("uart transmit", errs_before);

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/bus_decoder.sv
rtl/bram.sv
rtl/clint.sv
rtl/uart.sv
rtl/soc_bus.sv
sim/soc_bus_tb.sv
